// ==== src/loader_pkg.sv ====
// Loader shared definitions

`default_nettype none

package loader_pkg;

	// ====================
	// Basic types
	// ====================

	typedef logic [15:0] c64_addr_t;
	typedef logic [7:0]  byte_t;

	// PS/2 key event as delivered by the host
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// Loader FSM states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_HDR_LO,
		ST_HDR_HI,
		ST_BODY,
		ST_MEMINIT,
		ST_AUTOSTART
	} ld_state_t;

	// Scan codes typed by the autostart sequence
	typedef enum logic [7:0] {
		KEY_R      = 8'h2D,
		KEY_U      = 8'h3C,
		KEY_N      = 8'h31,
		KEY_RETURN = 8'h5A
	} key_code_e;

	// ====================
	// Constants
	// ====================

	localparam logic [31:0] KEY_STEP_CYCLES = 32'd1280000;
	localparam logic [3:0]  KEY_SEQ_STEPS   = 4'd8;
	localparam c64_addr_t   MEMINIT_LAST    = 16'h00FF;

	// BASIC text start as left by a cold start
	localparam byte_t TXT_PTR_LO = 8'h01;
	localparam byte_t TXT_PTR_HI = 8'h08;

endpackage

`default_nettype wire

// ==== src/mem_port_if.sv ====
// Memory write request port

`timescale 1ns/1ps
`default_nettype none

interface mem_port_if
	import loader_pkg::*;
();

	logic      req;
	c64_addr_t addr;
	byte_t     data;
	// One-cycle pulse when the write has gone out
	logic      ack;

	modport ctrl (
		output req,
		output addr,
		output data,
		input  ack
	);

	modport writer (
		input  req,
		input  addr,
		input  data,
		output ack
	);

endinterface

`default_nettype wire

// ==== src/step_timer.sv ====
// Key step timer

`timescale 1ns/1ps
`default_nettype none

module step_timer
	import loader_pkg::*;
#(
	parameter logic [31:0] STEP_CYCLES = KEY_STEP_CYCLES
) (
	input  wire logic clk_sys,
	input  wire logic reset_n,
	input  wire logic enable_i,
	output logic      step_o
);

	logic [31:0] count;
	logic        step_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			count  <= '0;
			step_q <= 1'b0;
		end else if (!enable_i) begin
			// Idle timer starts each sequence from zero
			count  <= '0;
			step_q <= 1'b0;
		end else if (count == STEP_CYCLES - 32'd1) begin
			count  <= '0;
			step_q <= 1'b1;
		end else begin
			count  <= count + 32'd1;
			step_q <= 1'b0;
		end
	end

	assign step_o = step_q;

endmodule

`default_nettype wire

// ==== src/key_injector.sv ====
// Autostart key injector

`timescale 1ns/1ps
`default_nettype none

module key_injector
	import loader_pkg::*;
(
	input  wire logic     clk_sys,
	input  wire logic     reset_n,
	input  wire logic     start_keys_i,
	input  wire logic     step_i,
	input  wire ps2_key_t ps2_key_i,
	output ps2_key_t      key_o,
	output logic          timer_en_o
);

	// Next step to emit, zero means passthrough
	logic [3:0] step_idx;
	ps2_key_t   key_q;
	key_code_e  seq_code;

	// Each key takes a press step and a release step
	always_comb begin
		case (step_idx)
			4'd1, 4'd2: seq_code = KEY_R;
			4'd3, 4'd4: seq_code = KEY_U;
			4'd5, 4'd6: seq_code = KEY_N;
			default:    seq_code = KEY_RETURN;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			step_idx <= '0;
			key_q    <= ps2_key_i;
		end else if (start_keys_i) begin
			step_idx <= 4'd1;
		end else if (step_idx != '0) begin
			if (step_i) begin
				key_q.strobe   <= ~key_q.strobe;
				key_q.pressed  <= step_idx[0];
				key_q.extended <= 1'b0;
				key_q.code     <= seq_code;
				if (step_idx == KEY_SEQ_STEPS) begin
					step_idx <= '0;
				end else begin
					step_idx <= step_idx + 4'd1;
				end
			end
		end else begin
			key_q <= ps2_key_i;
		end
	end

	assign key_o      = key_q;
	assign timer_en_o = (step_idx != '0);

	// ====================
	// Checks
	// ====================

	a_step_range: assert property (@(posedge clk_sys) disable iff (!reset_n)
		step_idx <= KEY_SEQ_STEPS);

	// Timer only ticks while a sequence runs
	a_step_when_active: assert property (@(posedge clk_sys) disable iff (!reset_n)
		step_i |-> step_idx != '0);

endmodule

`default_nettype wire

// ==== src/mem_slot_writer.sv ====
// Memory slot writer

`timescale 1ns/1ps
`default_nettype none

module mem_slot_writer
	import loader_pkg::*;
(
	input  wire logic  clk_sys,
	input  wire logic  reset_n,
	input  wire logic  io_cycle_i,
	mem_port_if.writer mem,
	output logic       mem_we_o,
	output c64_addr_t  mem_addr_o,
	output byte_t      mem_data_o
);

	logic io_cycle_q;
	logic slot_fall;
	logic we_q;

	// Free slot opens when io_cycle drops
	assign slot_fall = io_cycle_q && !io_cycle_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_q <= 1'b0;
			we_q       <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			we_q       <= slot_fall && mem.req && !we_q;
		end
	end

	// Pending write is captured into the output registers
	always_ff @(posedge clk_sys) begin
		if (slot_fall && mem.req) begin
			mem_addr_o <= mem.addr;
			mem_data_o <= mem.data;
		end
	end

	assign mem_we_o = we_q;
	assign mem.ack  = we_q;

	// ====================
	// Checks
	// ====================

	a_we_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |=> !mem_we_o);

	// Requester keeps its write steady until the ack
	a_req_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem.req && !mem.ack |=> mem.req && $stable(mem.addr) && $stable(mem.data));

endmodule

`default_nettype wire

// ==== src/load_ctrl_fsm.sv ====
// PRG load controller

`timescale 1ns/1ps
`default_nettype none

module load_ctrl_fsm
	import loader_pkg::*;
(
	input  wire logic      clk_sys,
	input  wire logic      reset_n,
	input  wire logic      ioctl_download_i,
	input  wire logic      ioctl_wr_i,
	input  wire c64_addr_t ioctl_addr_i,
	input  wire byte_t     ioctl_data_i,
	mem_port_if.ctrl       mem,
	output logic           ioctl_wait_o,
	output logic           start_keys_o
);

	ld_state_t state;
	c64_addr_t load_addr;
	c64_addr_t end_addr;
	c64_addr_t scan_addr;
	logic      req_q;
	c64_addr_t addr_q;
	byte_t     data_q;
	logic      tbl_hit;
	byte_t     tbl_data;

	// ====================
	// Zero-page pointer table
	// ====================

	// Same values a BASIC LOAD leaves behind
	always_comb begin
		tbl_hit  = 1'b1;
		tbl_data = '0;
		case (scan_addr)
			16'h002B: tbl_data = TXT_PTR_LO;
			16'h002C: tbl_data = TXT_PTR_HI;
			16'h00AC, 16'h00AD: tbl_data = '0;
			// VAR, ARY, STR and load end all point past the program
			16'h002D, 16'h002F, 16'h0031, 16'h00AE: tbl_data = end_addr[7:0];
			16'h002E, 16'h0030, 16'h0032, 16'h00AF: tbl_data = end_addr[15:8];
			default: tbl_hit = 1'b0;
		endcase
	end

	// ====================
	// State machine
	// ====================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state     <= ST_IDLE;
			req_q     <= 1'b0;
			scan_addr <= '0;
			load_addr <= '0;
			end_addr  <= '0;
			addr_q    <= '0;
			data_q    <= '0;
		end else begin
			case (state)
				ST_IDLE, ST_HDR_LO: begin
					// Header low byte is the first byte of the file
					if (!ioctl_download_i) begin
						state <= ST_IDLE;
					end else if (ioctl_wr_i && ioctl_addr_i == '0) begin
						load_addr[7:0] <= ioctl_data_i;
						end_addr[7:0]  <= ioctl_data_i;
						state          <= ST_HDR_HI;
					end else begin
						state <= ST_HDR_LO;
					end
				end
				ST_HDR_HI: begin
					if (!ioctl_download_i) begin
						state <= ST_IDLE;
					end else if (ioctl_wr_i) begin
						load_addr[15:8] <= ioctl_data_i;
						end_addr[15:8]  <= ioctl_data_i;
						state           <= ST_BODY;
					end
				end
				ST_BODY: begin
					if (req_q && mem.ack) begin
						req_q <= 1'b0;
					end
					if (ioctl_wr_i) begin
						req_q     <= 1'b1;
						addr_q    <= load_addr;
						data_q    <= ioctl_data_i;
						load_addr <= load_addr + 16'd1;
						end_addr  <= end_addr + 16'd1;
					end else if (!ioctl_download_i && !req_q) begin
						scan_addr <= '0;
						state     <= ST_MEMINIT;
					end
				end
				ST_MEMINIT: begin
					if (req_q) begin
						if (mem.ack) begin
							req_q     <= 1'b0;
							scan_addr <= scan_addr + 16'd1;
						end
					end else if (tbl_hit) begin
						req_q  <= 1'b1;
						addr_q <= scan_addr;
						data_q <= tbl_data;
					end else if (scan_addr == MEMINIT_LAST) begin
						state <= ST_AUTOSTART;
					end else begin
						scan_addr <= scan_addr + 16'd1;
					end
				end
				ST_AUTOSTART: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign mem.req  = req_q;
	assign mem.addr = addr_q;
	assign mem.data = data_q;

	// Host is held off while a body byte is in flight or pointers go out
	assign ioctl_wait_o = (state == ST_BODY && req_q) || state == ST_MEMINIT;

	// Autostart state lasts exactly one cycle
	assign start_keys_o = (state == ST_AUTOSTART);

	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ioctl_wait_o |-> !ioctl_wr_i);

endmodule

`default_nettype wire

// ==== src/prg_loader_top.sv ====
// PRG loader and autostart top level

`timescale 1ns/1ps
`default_nettype none

module prg_loader_top
	import loader_pkg::*;
#(
	parameter logic [31:0] STEP_CYCLES = KEY_STEP_CYCLES
) (
	input  wire logic      clk_sys,
	input  wire logic      reset_n,

	// Host download stream
	input  wire logic      ioctl_download_i,
	input  wire logic      ioctl_wr_i,
	input  wire c64_addr_t ioctl_addr_i,
	input  wire byte_t     ioctl_data_i,
	output logic           ioctl_wait_o,

	// Core memory slot
	input  wire logic      io_cycle_i,
	output logic           mem_we_o,
	output c64_addr_t      mem_addr_o,
	output byte_t          mem_data_o,

	// Keyboard path
	input  wire ps2_key_t  ps2_key_i,
	output ps2_key_t       key_o
);

	logic start_keys;
	logic timer_en;
	logic step;

	mem_port_if mem_port ();

	// ====================
	// Download and RAM injection
	// ====================

	load_ctrl_fsm u_ctrl (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.mem              (mem_port.ctrl),
		.ioctl_wait_o     (ioctl_wait_o),
		.start_keys_o     (start_keys)
	);

	mem_slot_writer u_writer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.mem        (mem_port.writer),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	// ====================
	// Autostart keys
	// ====================

	step_timer #(
		.STEP_CYCLES (STEP_CYCLES)
	) u_timer (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.enable_i (timer_en),
		.step_o   (step)
	);

	key_injector u_keys (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.start_keys_i (start_keys),
		.step_i       (step),
		.ps2_key_i    (ps2_key_i),
		.key_o        (key_o),
		.timer_en_o   (timer_en)
	);

endmodule

`default_nettype wire

// ==== tests/tb_prg_loader.sv ====
// PRG loader testbench

`timescale 1ns/1ps
`default_nettype none

module tb_prg_loader
	import loader_pkg::*;
();

	localparam int STEP_CYCLES = 16;
	localparam int BYTES_A = 20;
	localparam int BYTES_B = 3;
	// Slots arrive at random, so each write gets a generous allowance
	localparam int TIMEOUT_CYCLES = 4 * (16 * (BYTES_A + BYTES_B + 4) + 2 * (256 + 12 * 16)
		+ 2 * KEY_SEQ_STEPS * STEP_CYCLES) + 500;

	logic      clk_sys = 1'b0;
	logic      reset_n;
	logic      ioctl_download_i;
	logic      ioctl_wr_i;
	c64_addr_t ioctl_addr_i;
	byte_t     ioctl_data_i;
	logic      ioctl_wait_o;
	logic      io_cycle_i;
	logic      mem_we_o;
	c64_addr_t mem_addr_o;
	byte_t     mem_data_o;
	ps2_key_t  ps2_key_i;
	ps2_key_t  key_o;

	integer    seed = 32'h4d10317c;
	logic [31:0] rnd;
	int        cycle_count = 0;
	int        checks = 0;
	int        errors = 0;
	logic      io_prev = 1'b0;
	logic      io_cur = 1'b0;
	c64_addr_t exp_addr[$];
	byte_t     exp_data[$];

	prg_loader_top #(
		.STEP_CYCLES (STEP_CYCLES)
	) dut0 (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.io_cycle_i       (io_cycle_i),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.ps2_key_i        (ps2_key_i),
		.key_o            (key_o)
	);

	always #5 clk_sys = ~clk_sys;

	// ====================
	// Reference model
	// ====================

	function automatic byte_t body_byte(input int idx, input c64_addr_t load);
		return byte_t'(idx * 7 + load[15:8] + 8'h11);
	endfunction

	// Body writes first, then the zero-page pointers in address order
	function automatic void build_expected(input c64_addr_t load, input int n);
		c64_addr_t end_a;
		end_a = load + c64_addr_t'(n);
		for (int i = 0; i < n; i++) begin
			exp_addr.push_back(load + c64_addr_t'(i));
			exp_data.push_back(body_byte(i, load));
		end
		exp_addr.push_back(16'h002B);
		exp_data.push_back(8'h01);
		exp_addr.push_back(16'h002C);
		exp_data.push_back(8'h08);
		for (int k = 0; k < 3; k++) begin
			exp_addr.push_back(16'h002D + c64_addr_t'(2 * k));
			exp_data.push_back(end_a[7:0]);
			exp_addr.push_back(16'h002E + c64_addr_t'(2 * k));
			exp_data.push_back(end_a[15:8]);
		end
		exp_addr.push_back(16'h00AC);
		exp_data.push_back(8'h00);
		exp_addr.push_back(16'h00AD);
		exp_data.push_back(8'h00);
		exp_addr.push_back(16'h00AE);
		exp_data.push_back(end_a[7:0]);
		exp_addr.push_back(16'h00AF);
		exp_data.push_back(end_a[15:8]);
	endfunction

	// R, U, N, RETURN with a press on odd steps and a release on even ones
	function automatic ps2_key_t expected_key(input int step, input ps2_key_t prev);
		ps2_key_t k;
		k.strobe   = ~prev.strobe;
		k.pressed  = (step % 2 == 1);
		k.extended = 1'b0;
		case ((step + 1) / 2)
			1: k.code = 8'h2D;
			2: k.code = 8'h3C;
			3: k.code = 8'h31;
			default: k.code = 8'h5A;
		endcase
		return k;
	endfunction

	// ====================
	// Compare tasks
	// ====================

	task automatic check_write(input c64_addr_t want_addr, input byte_t want_data);
		checks++;
		if (mem_addr_o !== want_addr || mem_data_o !== want_data) begin
			errors++;
			$display("FAIL %0t mem_addr_o/mem_data_o expected %h/%h got %h/%h",
				$time, want_addr, want_data, mem_addr_o, mem_data_o);
		end
	endtask

	task automatic check_key(input ps2_key_t want);
		checks++;
		if (key_o !== want) begin
			errors++;
			$display("FAIL %0t key_o expected %h got %h", $time, want, key_o);
		end
	endtask

	task automatic check_wait(input logic want);
		checks++;
		if (ioctl_wait_o !== want) begin
			errors++;
			$display("FAIL %0t ioctl_wait_o expected %b got %b", $time, want, ioctl_wait_o);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_before);
	endtask

	// Write monitor samples mid-cycle where outputs have settled
	always @(negedge clk_sys) begin
		if (mem_we_o) begin
			if (!(io_prev && !io_cur)) begin
				errors++;
				$display("Write pulse at %0t without a falling edge of io_cycle_i", $time);
			end
			// Host stays held off until every write has gone out
			check_wait(1'b1);
			if (exp_addr.size() == 0) begin
				errors++;
				$display("Unexpected write at %0t to address %h", $time, mem_addr_o);
			end else begin
				check_write(exp_addr.pop_front(), exp_data.pop_front());
			end
		end
		io_prev = io_cur;
		io_cur  = io_cycle_i;
	end

	// Random free memory slots
	always @(posedge clk_sys) begin
		#1;
		rnd = $random(seed);
		io_cycle_i = rnd[9];
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ====================
	// Stimulus
	// ====================

	task automatic send_prg(input c64_addr_t load, input int n);
		ioctl_download_i = 1'b1;
		for (int i = 0; i < n + 2; i++) begin
			ioctl_addr_i = c64_addr_t'(i);
			if (i == 0)
				ioctl_data_i = load[7:0];
			else if (i == 1)
				ioctl_data_i = load[15:8];
			else
				ioctl_data_i = body_byte(i - 2, load);
			ioctl_wr_i = 1'b1;
			@(posedge clk_sys);
			#1;
			ioctl_wr_i = 1'b0;
			// Header bytes leave the host free, body bytes hold it off
			check_wait(i >= 2);
			while (ioctl_wait_o) begin
				@(posedge clk_sys);
				#1;
			end
		end
		ioctl_download_i = 1'b0;
	endtask

	task automatic load_and_run(input string name, input c64_addr_t load, input int n);
		int err_before;
		ps2_key_t want;
		err_before = errors;
		build_expected(load, n);
		send_prg(load, n);
		want = ps2_key_i;
		for (int step = 1; step <= KEY_SEQ_STEPS; step++) begin
			@(negedge clk_sys);
			while (key_o === want)
				@(negedge clk_sys);
			want = expected_key(step, want);
			check_key(want);
		end
		repeat (2) @(negedge clk_sys);
		check_key(ps2_key_i);
		check_wait(1'b0);
		if (exp_addr.size() != 0) begin
			errors++;
			$display("%0d expected writes never happened", exp_addr.size());
			exp_addr.delete();
			exp_data.delete();
		end
		report_test(name, err_before);
	endtask

	initial begin
		int err_before;
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		io_cycle_i       = 1'b1;
		ps2_key_i        = '0;
		repeat (4) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;

		// Host keys pass through while idle
		err_before = errors;
		for (int i = 0; i < 6; i++) begin
			@(posedge clk_sys);
			#1;
			ps2_key_i = ps2_key_t'({i[0], 2'b10, byte_t'(8'h1C + i)});
			repeat (2) @(negedge clk_sys);
			check_key(ps2_key_i);
		end
		ps2_key_i = '0;
		repeat (4) @(posedge clk_sys);
		#1;
		report_test("idle passthrough", err_before);

		load_and_run("prg 0801 x20", 16'h0801, BYTES_A);
		repeat (4) @(posedge clk_sys);
		#1;
		load_and_run("prg C000 x3", 16'hC000, BYTES_B);

		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
src/loader_pkg.sv
src/mem_port_if.sv
src/step_timer.sv
src/key_injector.sv
src/mem_slot_writer.sv
src/load_ctrl_fsm.sv
src/prg_loader_top.sv
tests/tb_prg_loader.sv

// ==== Bender.yml ====
package:
  name: prg_loader

sources:
  - files:
      - src/loader_pkg.sv
      - src/mem_port_if.sv
      - src/step_timer.sv
      - src/key_injector.sv
      - src/mem_slot_writer.sv
      - src/load_ctrl_fsm.sv
      - src/prg_loader_top.sv
  - target: test
    files:
      - tests/tb_prg_loader.sv
